//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

  // ********************
  // major opcodes
  // ********************
  typedef enum logic [4:0] {
    opHalt  = 5'b00000,
    opNop   = 5'b00001,
    opAddi  = 5'b01000,
    opSubi  = 5'b01001,
    opXori  = 5'b01010,
    opAndni = 5'b01011,
    opSt    = 5'b10000,
    opLd    = 5'b10001,
    opLbi   = 5'b11000,
    opAluR  = 5'b11011   // func picks add, sub, xor or andn
  } opcodeT;

  // field positions inside the instruction word
  localparam int opcMsb  = 15;
  localparam int opcLsb  = 11;
  localparam int rsMsb   = 10;
  localparam int rsLsb   = 8;
  localparam int rtMsb   = 7;
  localparam int rtLsb   = 5;
  localparam int rdMsb   = 4;
  localparam int rdLsb   = 2;
  localparam int funcMsb = 1;
  localparam int funcLsb = 0;
  localparam int imm5Msb = 4;
  localparam int imm8Msb = 7;

  // r-format function codes
  localparam logic [1:0] fnAdd  = 2'b00;
  localparam logic [1:0] fnSub  = 2'b01;
  localparam logic [1:0] fnXor  = 2'b10;
  localparam logic [1:0] fnAndn = 2'b11;

  localparam logic [15:0] NOP_WORD = {opNop, 11'b0};

endpackage

`default_nettype wire

//--- src/pipePkg.sv
`default_nettype none

package pipePkg;

  typedef logic [2:0] regIdxT;

  typedef enum logic [1:0] {
    aluAdd   = 2'b00,
    aluXor   = 2'b01,
    aluAndn  = 2'b10,   // and of operand 1 with the inverted operand 2
    aluPassB = 2'b11    // lbi
  } aluOpT;

  // ********************
  // id/ex latch contents
  // ********************
  typedef struct packed {
    logic   regWrite;
    logic   memWrite;
    logic   memEn;
    logic   memToReg;   // set only by loads
    logic   halt;
    logic   branching;
    logic   invA;
    logic   invB;
    logic   cin;
    logic   aluSrc2;    // 1 selects imm
    aluOpT  aluOp;
    regIdxT writeReg;
  } exCtrlT;

  typedef struct packed {
    logic [15:0] pc;
    logic [15:0] opA;
    logic [15:0] opB;
    logic [15:0] imm;
    logic [15:0] instruction;
    logic        readingRt;
  } exDataT;

endpackage

`default_nettype wire

//--- src/ctrlIf.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;
  import pipePkg::*;

  logic   regWrite, memWrite, memEn, memToReg, halt, branching;
  logic   invA, invB, cin, aluSrc2;
  aluOpT  aluOp;
  regIdxT writeReg;

  modport decoder (output regWrite, memWrite, memEn, memToReg, halt, branching,
                   invA, invB, cin, aluSrc2, aluOp, writeReg);
  modport latchIn (input regWrite, memWrite, memEn, memToReg, halt, branching,
                   invA, invB, cin, aluSrc2, aluOp, writeReg);
  modport latchOut (output regWrite, memWrite, memEn, memToReg, halt, branching,
                    invA, invB, cin, aluSrc2, aluOp, writeReg);
  // execute only needs the operand and function controls
  modport alu (input invA, invB, cin, aluSrc2, aluOp);

endinterface

`default_nettype wire

//--- src/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
  input  logic [15:0]     instr,
  output pipePkg::regIdxT opA,
  output pipePkg::regIdxT opB,
  output logic [15:0]     imm,
  output logic            readingRs,
  output logic            readingRt,
  ctrlIf.decoder          ctrl
);
  import isaPkg::*;
  import pipePkg::*;

  opcodeT      opc;
  logic [1:0]  func;
  logic [15:0] sext5, zext5, sext8;

  assign opc  = opcodeT'(instr[opcMsb:opcLsb]);
  assign func = instr[funcMsb:funcLsb];
  assign opA  = instr[rsMsb:rsLsb];
  assign opB  = instr[rtMsb:rtLsb];

  assign sext5 = {{(15 - imm5Msb){instr[imm5Msb]}}, instr[imm5Msb:0]};
  assign zext5 = {{(15 - imm5Msb){1'b0}}, instr[imm5Msb:0]};
  assign sext8 = {{(15 - imm8Msb){instr[imm8Msb]}}, instr[imm8Msb:0]};

  always_comb begin
    // defaults are those of a nop
    ctrl.regWrite  = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.memEn     = 1'b0;
    ctrl.memToReg  = 1'b0;
    ctrl.halt      = 1'b0;
    ctrl.branching = 1'b0;   // no branches in this subset
    ctrl.invA      = 1'b0;
    ctrl.invB      = 1'b0;
    ctrl.cin       = 1'b0;
    ctrl.aluSrc2   = 1'b1;
    ctrl.aluOp     = aluAdd;
    ctrl.writeReg  = instr[rtMsb:rtLsb];
    imm            = sext5;
    readingRs      = 1'b0;
    readingRt      = 1'b0;

    case (opc)
      opHalt: ctrl.halt = 1'b1;
      opAddi, opSubi, opXori, opAndni: begin
        ctrl.regWrite = 1'b1;
        readingRs     = 1'b1;
        if (opc == opSubi) begin  // imm - rs
          ctrl.invA = 1'b1;
          ctrl.cin  = 1'b1;
        end
        if (opc == opXori || opc == opAndni) imm = zext5;
        if (opc == opXori) ctrl.aluOp = aluXor;
        if (opc == opAndni) begin
          ctrl.aluOp = aluAndn;
          ctrl.invB  = 1'b1;
        end
      end
      opLd: begin
        ctrl.regWrite = 1'b1;
        ctrl.memEn    = 1'b1;
        ctrl.memToReg = 1'b1;
        readingRs     = 1'b1;
      end
      opSt: begin
        ctrl.memEn    = 1'b1;
        ctrl.memWrite = 1'b1;
        readingRs     = 1'b1;
        readingRt     = 1'b1;   // store data
      end
      opLbi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluPassB;
        ctrl.writeReg = instr[rsMsb:rsLsb];
        imm           = sext8;
      end
      opAluR: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc2  = 1'b0;
        ctrl.writeReg = instr[rdMsb:rdLsb];
        readingRs     = 1'b1;
        readingRt     = 1'b1;
        case (func)
          fnSub: begin
            ctrl.invA = 1'b1;   // rt - rs
            ctrl.cin  = 1'b1;
          end
          fnXor: ctrl.aluOp = aluXor;
          fnAndn: begin
            ctrl.aluOp = aluAndn;
            ctrl.invB  = 1'b1;
          end
          default: ctrl.aluOp = aluAdd;
        endcase
      end
      default: ;   // nop and unknown opcodes
    endcase
  end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic            clk,
  input  logic            reset,
  input  pipePkg::regIdxT readRegA,
  input  pipePkg::regIdxT readRegB,
  output logic [15:0]     readDataA,
  output logic [15:0]     readDataB,
  input  logic            wbEn,
  input  pipePkg::regIdxT wbReg,
  input  logic [15:0]     wbData
);

  logic [15:0] regs [8];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) regs[i] <= '0;
    end else if (wbEn) begin
      regs[wbReg] <= wbData;
    end
  end

  // write-before-read bypass
  assign readDataA = (wbEn && wbReg == readRegA) ? wbData : regs[readRegA];
  assign readDataB = (wbEn && wbReg == readRegB) ? wbData : regs[readRegB];

  // ********************
  // checks
  // ********************
  wbRegKnown: assert property (@(posedge clk) disable iff (reset)
    wbEn |-> !$isunknown(wbReg))
    else $error("write-back to an unknown register");

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
  input  logic            exMemToReg,
  input  pipePkg::regIdxT exWriteReg,
  input  pipePkg::regIdxT decodeRs,
  input  pipePkg::regIdxT decodeRt,
  input  logic            readingRs,
  input  logic            readingRt,
  output logic            stall
);

  logic rsMatch, rtMatch;

  // load in execute whose result decode wants right now
  assign rsMatch = readingRs && (decodeRs == exWriteReg);
  assign rtMatch = readingRt && (decodeRt == exWriteReg);

  assign stall = exMemToReg && (rsMatch || rtMatch);

endmodule

`default_nettype wire

//--- src/stageReg.sv
`timescale 1ns/10ps
`default_nettype none

module stageReg #(
  parameter type payloadT      = logic [15:0],
  parameter bit  clearOnBubble = 1'b0
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    en,
  input  logic    bubble,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (en) begin
      if (clearOnBubble && bubble) q <= '0;
      else q <= d;
    end
  end

endmodule

`default_nettype wire

//--- src/idExLatch.sv
`timescale 1ns/10ps
`default_nettype none

module idExLatch (
  input  logic            clk,
  input  logic            reset,
  input  logic            hold,
  input  logic            stall,
  input  logic            instrValid,
  input  pipePkg::exDataT dataIn,
  ctrlIf.latchIn          ctrlIn,
  output pipePkg::exDataT dataOut,
  ctrlIf.latchOut         ctrlOut,
  output logic            valid
);
  import isaPkg::*;
  import pipePkg::*;

  logic   bubble;
  exDataT dataD;
  exCtrlT ctrlD, ctrlQ;

  assign bubble = stall || !instrValid;   // nothing accepted this cycle

  always_comb begin
    dataD = dataIn;
    if (bubble) dataD.instruction = NOP_WORD;
  end

  assign ctrlD = '{regWrite: ctrlIn.regWrite, memWrite: ctrlIn.memWrite,
                   memEn: ctrlIn.memEn, memToReg: ctrlIn.memToReg,
                   halt: ctrlIn.halt, branching: ctrlIn.branching,
                   invA: ctrlIn.invA, invB: ctrlIn.invB, cin: ctrlIn.cin,
                   aluSrc2: ctrlIn.aluSrc2, aluOp: ctrlIn.aluOp,
                   writeReg: ctrlIn.writeReg};

  stageReg #(.payloadT(exDataT), .clearOnBubble(1'b0)) dataReg (
    .clk, .reset, .en(!hold), .bubble, .d(dataD), .q(dataOut));

  stageReg #(.payloadT(exCtrlT), .clearOnBubble(1'b1)) ctrlReg (
    .clk, .reset, .en(!hold), .bubble, .d(ctrlD), .q(ctrlQ));

  always_ff @(posedge clk) begin
    if (reset) valid <= 1'b0;
    else if (!hold) valid <= !bubble;
  end

  assign ctrlOut.regWrite  = ctrlQ.regWrite;
  assign ctrlOut.memWrite  = ctrlQ.memWrite;
  assign ctrlOut.memEn     = ctrlQ.memEn;
  assign ctrlOut.memToReg  = ctrlQ.memToReg;
  assign ctrlOut.halt      = ctrlQ.halt;
  assign ctrlOut.branching = ctrlQ.branching;
  assign ctrlOut.invA      = ctrlQ.invA;
  assign ctrlOut.invB      = ctrlQ.invB;
  assign ctrlOut.cin       = ctrlQ.cin;
  assign ctrlOut.aluSrc2   = ctrlQ.aluSrc2;
  assign ctrlOut.aluOp     = ctrlQ.aluOp;
  assign ctrlOut.writeReg  = ctrlQ.writeReg;

  bubbleIsClean: assert property (@(posedge clk) disable iff (reset)
    (!hold && bubble) |=> (ctrlQ == '0 && !valid))
    else $error("control bits set after a bubble");

endmodule

`default_nettype wire

//--- src/aluExec.sv
`timescale 1ns/10ps
`default_nettype none

module aluExec (
  input  pipePkg::exDataT dataIn,
  ctrlIf.alu              ctrl,
  output logic [15:0]     result,
  output logic [15:0]     storeData
);
  import pipePkg::*;

  logic [15:0] srcB;
  logic [15:0] inA, inB;
  logic [15:0] sum;

  // ********************
  // operand selection
  // ********************
  assign srcB = ctrl.aluSrc2 ? dataIn.imm : dataIn.opB;

  assign inA = ctrl.invA ? ~dataIn.opA : dataIn.opA;   // sub computes b - a
  assign inB = ctrl.invB ? ~srcB : srcB;

  assign sum = inA + inB + {15'b0, ctrl.cin};

  // ********************
  // function select
  // ********************
  always_comb begin
    case (ctrl.aluOp)
      aluAdd:   result = sum;
      aluXor:   result = inA ^ inB;
      aluAndn:  result = inA & inB;   // inB already inverted by invB
      aluPassB: result = inB;
      default:  result = sum;
    endcase
  end

  // st writes the rt value
  assign storeData = dataIn.opB;

endmodule

`default_nettype wire

//--- src/decodeExecute.sv
`timescale 1ns/10ps
`default_nettype none

module decodeExecute (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] instr,
  input  logic [15:0] pc,
  input  logic        instrValid,
  output logic        instrReady,
  input  logic        hold,
  input  logic        wbEn,
  input  logic [2:0]  wbReg,
  input  logic [15:0] wbData,
  output logic        exValid,
  output logic [15:0] exResult,
  output logic [2:0]  exWriteReg,
  output logic        exRegWrite,
  output logic        exMemWrite,
  output logic        exMemToReg,
  output logic [15:0] exStoreData,
  output logic        exHalt
);
  import pipePkg::*;

  regIdxT      rsIdx, rtIdx;
  logic [15:0] imm, rsData, rtData;
  logic        readingRs, readingRt, stall;
  exDataT      idData, exData;

  ctrlIf idCtrl ();   // decoder to latch
  ctrlIf exCtrl ();   // latch to execute

  instrDecode decode (.instr, .opA(rsIdx), .opB(rtIdx), .imm, .readingRs, .readingRt,
                      .ctrl(idCtrl.decoder));

  regFile regs (.clk, .reset, .readRegA(rsIdx), .readRegB(rtIdx), .readDataA(rsData),
                .readDataB(rtData), .wbEn, .wbReg, .wbData);

  hazardUnit hazard (.exMemToReg(exCtrl.memToReg), .exWriteReg(exCtrl.writeReg),
                     .decodeRs(rsIdx), .decodeRt(rtIdx), .readingRs, .readingRt, .stall);

  assign idData = '{pc: pc, opA: rsData, opB: rtData, imm: imm, instruction: instr,
                    readingRt: readingRt};

  idExLatch latch (.clk, .reset, .hold, .stall, .instrValid, .dataIn(idData),
                   .ctrlIn(idCtrl.latchIn), .dataOut(exData), .ctrlOut(exCtrl.latchOut),
                   .valid(exValid));

  aluExec alu (.dataIn(exData), .ctrl(exCtrl.alu), .result(exResult),
               .storeData(exStoreData));

  assign instrReady = !(stall || hold);

  assign exWriteReg = exCtrl.writeReg;
  assign exRegWrite = exCtrl.regWrite;
  assign exMemWrite = exCtrl.memWrite;
  assign exMemToReg = exCtrl.memToReg;
  assign exHalt     = exCtrl.halt;

endmodule

`default_nettype wire

//--- tb/resultChecker.sv
`timescale 1ns/10ps
`default_nettype none

module resultChecker (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] instr,
  input  logic        instrValid,
  input  logic        instrReady,
  input  logic        hold,
  input  logic        wbEn,
  input  logic [2:0]  wbReg,
  input  logic [15:0] wbData,
  input  logic        exValid,
  input  logic [15:0] exResult,
  input  logic [2:0]  exWriteReg,
  input  logic        exRegWrite, exMemWrite, exMemToReg, exHalt,
  input  logic [15:0] exStoreData,
  output int          errors,
  output int          checked,
  output int          pending
);
  import isaPkg::*;

  typedef struct packed {
    logic [15:0] result;
    logic [15:0] storeData;
    logic [2:0]  writeReg;
    logic        useResult;
    logic        regWrite;
    logic        memWrite;
    logic        memToReg;
    logic        halt;
    logic        readsRs;
    logic        readsRt;
  } expectT;

  logic [15:0] model [8];
  expectT      inFlight [$];   // accepted but not yet gone from execute
  logic        latchFull = 1'b0;
  int          errorCount = 0;
  int          checkCount = 0;
  int          queued = 0;

  assign errors  = errorCount;
  assign checked = checkCount;
  assign pending = queued;

  // reference model of one instruction
  function automatic expectT predict(input logic [15:0] word, input logic [15:0] rsVal,
                                     input logic [15:0] rtVal);
    expectT      e;
    logic [4:0]  opc;
    logic [15:0] s5, z5;
    opc = word[opcMsb:opcLsb];
    s5  = {{11{word[imm5Msb]}}, word[imm5Msb:0]};
    z5  = {11'b0, word[imm5Msb:0]};
    e   = '0;
    e.storeData = rtVal;
    e.regWrite  = opc inside {opAddi, opSubi, opXori, opAndni, opLd, opLbi, opAluR};
    e.memWrite  = (opc == opSt);
    e.memToReg  = (opc == opLd);
    e.halt      = (opc == opHalt);
    e.readsRs   = opc inside {opAddi, opSubi, opXori, opAndni, opLd, opSt, opAluR};
    e.readsRt   = opc inside {opSt, opAluR};
    e.useResult = e.regWrite || e.memWrite;
    e.writeReg  = (opc == opAluR) ? word[rdMsb:rdLsb] :
                  (opc == opLbi) ? word[rsMsb:rsLsb] : word[rtMsb:rtLsb];
    case (opc)
      opSubi:  e.result = s5 - rsVal;
      opXori:  e.result = rsVal ^ z5;
      opAndni: e.result = rsVal & ~z5;
      opLbi:   e.result = {{8{word[imm8Msb]}}, word[imm8Msb:0]};
      opAluR:
        case (word[funcMsb:funcLsb])
          fnAdd:   e.result = rsVal + rtVal;
          fnSub:   e.result = rtVal - rsVal;
          fnXor:   e.result = rsVal ^ rtVal;
          default: e.result = rsVal & ~rtVal;
        endcase
      default: e.result = rsVal + s5;   // addi and the ld/st address
    endcase
    return e;
  endfunction

  task automatic expectValue(input string name, input logic [15:0] got,
                             input logic [15:0] want);
    checkCount++;
    if (got !== want) begin
      errorCount++;
      $display("** Error %s: got %h, expected %h at %0t", name, got, want, $time);
    end
  endtask

  // outputs are settled mid-cycle, and so are the inputs for the next edge
  always @(negedge clk) begin : sample
    expectT head, offered;
    logic   hazard;
    if (reset) begin
      for (int i = 0; i < 8; i++) model[i] = '0;
      inFlight.delete();
      latchFull = 1'b0;
    end else begin
      expectValue("exValid", 16'(exValid), 16'(latchFull));
      head = '0;   // an empty latch carries no control bits
      if (latchFull) head = inFlight[0];
      expectValue("exRegWrite", 16'(exRegWrite), 16'(head.regWrite));
      expectValue("exMemWrite", 16'(exMemWrite), 16'(head.memWrite));
      expectValue("exMemToReg", 16'(exMemToReg), 16'(head.memToReg));
      expectValue("exHalt", 16'(exHalt), 16'(head.halt));
      if (head.useResult) expectValue("exResult", exResult, head.result);
      if (head.regWrite) expectValue("exWriteReg", 16'(exWriteReg), 16'(head.writeReg));
      if (head.memWrite) expectValue("exStoreData", exStoreData, head.storeData);

      // does decode wait on the load in execute
      offered = predict(instr, 16'd0, 16'd0);
      hazard  = head.memToReg &&
                ((offered.readsRs && instr[rsMsb:rsLsb] == head.writeReg) ||
                 (offered.readsRt && instr[rtMsb:rtLsb] == head.writeReg));
      expectValue("instrReady", 16'(instrReady), 16'(!hold && !hazard));

      if (wbEn) model[wbReg] = wbData;   // seen by this edge's read too
      if (!hold) begin
        if (latchFull && inFlight.size() != 0) void'(inFlight.pop_front());
        latchFull = instrValid && instrReady;
        if (latchFull) begin
          inFlight.push_back(predict(instr, model[instr[rsMsb:rsLsb]],
                                     model[instr[rtMsb:rtLsb]]));
        end
      end
    end
    queued = inFlight.size();
  end

endmodule

`default_nettype wire

//--- tb/tbTop.sv
`timescale 1ns/10ps
`default_nettype none

module tbTop;
  import isaPkg::*;

  localparam int clkPeriod    = 4;
  localparam int plannedInstr = 46;
  localparam int watchdogNs   = 20 + plannedInstr * 3 * clkPeriod;

  logic        clk, reset;
  logic [15:0] instr, pc, pcNext;
  logic        instrValid, instrReady, hold;
  logic        wbEn;
  logic [2:0]  wbReg;
  logic [15:0] wbData;
  logic        exValid, exRegWrite, exMemWrite, exMemToReg, exHalt;
  logic [15:0] exResult, exStoreData;
  logic [2:0]  exWriteReg;
  int          errors, checked, pending;
  int          seed = 32'hfba;

  decodeExecute DUT (.clk, .reset, .instr, .pc, .instrValid, .instrReady, .hold, .wbEn,
    .wbReg, .wbData, .exValid, .exResult, .exWriteReg, .exRegWrite, .exMemWrite,
    .exMemToReg, .exStoreData, .exHalt);

  resultChecker checks (.clk, .reset, .instr, .instrValid, .instrReady, .hold, .wbEn,
    .wbReg, .wbData, .exValid, .exResult, .exWriteReg, .exRegWrite, .exMemWrite,
    .exMemToReg, .exStoreData, .exHalt, .errors, .checked, .pending);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(watchdogNs);
    $display("timeout: the run did not finish within %0d ns", watchdogNs);
    $display("tests failed");
    $finish;
  end

  // ********************
  // encoders and drivers
  // ********************
  function automatic logic [15:0] immWord(input opcodeT op, input logic [2:0] rs,
                                          input logic [2:0] rt, input logic [4:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [15:0] rWord(input logic [2:0] rs, input logic [2:0] rt,
                                        input logic [2:0] rd, input logic [1:0] fn);
    return {opAluR, rs, rt, rd, fn};
  endfunction

  function automatic logic [15:0] lbiWord(input logic [2:0] rs, input logic [7:0] imm);
    return {opLbi, rs, imm};
  endfunction

  // offer one instruction and wait until it is taken
  task automatic issue(input logic [15:0] word);
    logic taken;
    instr      = word;
    pc         = pcNext;
    instrValid = 1'b1;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = instrReady;   // stable by now
      @(posedge clk);
      #0.5;
    end
    instrValid = 1'b0;
    pcNext     = pcNext + 16'd2;
  endtask

  task automatic issueRandomImm(input opcodeT op);
    issue(immWord(op, 3'($random(seed)), 3'($random(seed)), 5'($random(seed))));
  endtask

  task automatic issueRandomR(input logic [1:0] fn);
    issue(rWord(3'($random(seed)), 3'($random(seed)), 3'($random(seed)), fn));
  endtask

  task automatic writeBack(input logic [2:0] r, input logic [15:0] d);
    wbEn   = 1'b1;
    wbReg  = r;
    wbData = d;
    @(posedge clk);
    #0.5;
    wbEn = 1'b0;
  endtask

  task automatic holdCycles(input int n);
    hold = 1'b1;
    repeat (n) @(posedge clk);
    #0.5;
    hold = 1'b0;
  endtask

  initial begin
    reset      = 1'b1;
    instr      = NOP_WORD;
    pc         = '0;
    pcNext     = '0;
    instrValid = 1'b0;
    hold       = 1'b0;
    wbEn       = 1'b0;
    wbReg      = '0;
    wbData     = '0;
    repeat (2) @(posedge clk);
    #0.5;
    reset = 1'b0;
    @(posedge clk);
    #0.5;

    // every register still reads zero
    issue(rWord(3'd0, 3'd1, 3'd2, fnAdd));
    issue(rWord(3'd2, 3'd3, 3'd4, fnXor));
    issue(rWord(3'd4, 3'd5, 3'd6, fnAdd));
    issue(rWord(3'd6, 3'd7, 3'd1, fnAndn));

    for (int i = 0; i < 8; i++) writeBack(3'(i), 16'($random(seed)));

    repeat (3) begin
      issueRandomImm(opAddi);
      issueRandomImm(opSubi);
      issueRandomImm(opXori);
      issueRandomImm(opAndni);
    end
    for (int f = 0; f < 4; f++) begin
      issueRandomR(2'(f));
      issueRandomR(2'(f));
    end
    issue(lbiWord(3'd2, 8'h5a));
    issue(lbiWord(3'd6, 8'hc3));   // negative
    issueRandomImm(opLd);
    issueRandomImm(opLd);
    issueRandomImm(opSt);
    issueRandomImm(opSt);

    // ********************
    // load-use
    // ********************
    issue(immWord(opLd, 3'd1, 3'd2, 5'd3));
    issue(rWord(3'd2, 3'd3, 3'd4, fnAdd));   // waits on rs
    issue(immWord(opLd, 3'd0, 3'd5, 5'd1));
    issue(immWord(opSt, 3'd1, 3'd5, 5'd2));  // waits on rt
    issue(immWord(opLd, 3'd4, 3'd6, 5'h1f));
    issue(immWord(opAddi, 3'd1, 3'd6, 5'd7));
    issue(immWord(opLd, 3'd2, 3'd3, 5'd0));
    issue(lbiWord(3'd3, 8'h11));

    // back-pressure once on an addi and once on a load in the latch
    issue(immWord(opAddi, 3'd5, 3'd0, 5'd9));
    fork
      holdCycles(3);
      issue(immWord(opXori, 3'd5, 3'd1, 5'h15));
    join
    issue(immWord(opLd, 3'd3, 3'd7, 5'd4));
    fork
      holdCycles(2);
      issue(rWord(3'd7, 3'd0, 3'd2, fnSub));
    join

    // write-back in the same cycle as the read, on rt and then on rs
    wbEn   = 1'b1;
    wbReg  = 3'd3;
    wbData = 16'($random(seed));
    issue(rWord(3'd4, 3'd3, 3'd5, fnAdd));
    wbReg  = 3'd4;
    wbData = 16'($random(seed));
    issue(immWord(opSubi, 3'd4, 3'd0, 5'h0c));
    wbEn = 1'b0;

    issue(NOP_WORD);
    issue({opHalt, 11'd0});

    wait (pending == 0);
    @(negedge clk);
    #1;
    $display("%0d checks, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/isaPkg.sv
src/pipePkg.sv
src/ctrlIf.sv
src/instrDecode.sv
src/regFile.sv
src/hazardUnit.sv
src/stageReg.sv
src/idExLatch.sv
src/aluExec.sv
src/decodeExecute.sv
tb/resultChecker.sv
tb/tbTop.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tbTop
FILELIST  = list.f
OBJDIR    = obj_dir
PASS      = all tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary -j 0 $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)
